// ==== project.f ====
+incdir+hw
hw/upsample_cfg_pkg.sv
hw/upsample_stream_pkg.sv
hw/upsample_regs.sv
hw/row_buffer.sv
hw/map_tracker.sv
hw/row_doubler.sv
hw/upsample_top.sv
dv/tb_clkgen.sv
dv/upsample_assert.sv
dv/upsample_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the upsampler testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
	--top-module upsample_tb -f project.f -Mdir obj_dir -o upsample_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/upsample_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "sim passed" sim.log; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1

// ==== dv/upsample_tb.sv ====
`timescale 1ns/10ps
`include "upsample_macros.svh"

module upsample_tb;

	import upsample_cfg_pkg::*;
	import upsample_stream_pkg::*;

	// 2*W*H*C beats for each map below
	localparam int TOTAL_BEATS = 2 * (2*3*1 + 4*2*3 + 5*4*2 + 2*2*1 + `MAX_MAP_W);
	localparam int WATCHDOG_CYCLES = 20 * TOTAL_BEATS + 2000;

	logic clk;
	logic reset;
	logic reg_wr;
	logic reg_rd;
	reg_addr_e reg_addr;
	logic[31:0] reg_wdata;
	logic[31:0] reg_rdata;
	logic in_valid;
	logic in_ready;
	pixel_t in_pixel;
	logic out_valid;
	logic out_ready;
	out_beat_t out_beat;
	logic itr;

	pixel_t pix_q[$]; // input map, channel then row order
	out_beat_t exp_q[$];
	string test_name;
	int beats_seen;
	bit ready_random;

	tb_clkgen clkgen_u(.clk(clk), .reset(reset));

	upsample_top DUT(
		.clk(clk),
		.reset(reset),
		.reg_wr(reg_wr),
		.reg_rd(reg_rd),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_rdata(reg_rdata),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_pixel(in_pixel),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_beat(out_beat),
		.itr(itr)
	);

	bind row_doubler upsample_assert assert_u(
		.clk(clk),
		.reset(reset),
		.busy(busy),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_beat(out_beat),
		.frame_done(frame_done)
	);

	task automatic stop_on_error(string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_beat(out_beat_t exp, out_beat_t act);
		if (act !== exp)
			stop_on_error($sformatf("FAILED %s beat %0d: expected %h/%b, actual %h/%b",
				test_name, beats_seen, exp.data, exp.last, act.data, act.last));
	endtask

	task automatic check_word(string what, logic[31:0] exp, logic[31:0] act);
		if (act !== exp)
			stop_on_error($sformatf("FAILED %s %s: expected %h, actual %h",
				test_name, what, exp, act));
	endtask

	task automatic reg_write(reg_addr_e addr, logic[31:0] data);
		reg_wr = 1'b1;
		reg_addr = addr;
		reg_wdata = data;
		@(posedge clk);
		#1;
		reg_wr = 1'b0;
	endtask

	task automatic reg_read(reg_addr_e addr, output logic[31:0] data);
		reg_rd = 1'b1;
		reg_addr = addr;
		@(posedge clk);
		#1;
		reg_rd = 1'b0;
		data = reg_rdata; // registered at the edge just passed
	endtask

	task automatic configure(int w, int h, int c);
		map_dims_t dims;
		dims.w_m1 = 16'(w - 1);
		dims.h_m1 = 16'(h - 1);
		reg_write(REG_DIMS, dims);
		reg_write(REG_CHN, 32'(c - 1));
	endtask

	task automatic fill_pixels(int n, bit rnd);
		pix_q.delete();
		for (int i = 0; i < n; i++)
			pix_q.push_back(rnd ? pixel_t'($urandom) : pixel_t'(16'h1000 + i));
	endtask

	// reference model, each row twice with every pixel doubled
	task automatic expect_map(int w, int h, int c);
		out_beat_t b;
		for (int ch = 0; ch < c; ch++)
			for (int y = 0; y < h; y++)
				for (int pass = 0; pass < 2; pass++)
					for (int x = 0; x < w; x++) begin
						b.data = {2{pix_q[(ch * h + y) * w + x]}};
						b.last = (ch == c - 1) && (y == h - 1) && (pass == 1) && (x == w - 1);
						exp_q.push_back(b);
					end
	endtask

	task automatic send_pixels(int first, int count);
		for (int i = first; i < first + count; i++) begin
			in_valid = 1'b1;
			in_pixel = pix_q[i];
			@(negedge clk);
			while (!in_ready)
				@(negedge clk);
			@(posedge clk); // transfer happens here
			#1;
		end
		in_valid = 1'b0;
	endtask

	task automatic run_map(string name, int w, int h, int c, bit rnd_pix, bit rnd_ready);
		logic[31:0] status;
		test_name = name;
		ready_random = rnd_ready;
		beats_seen = 0;
		fill_pixels(w * h * c, rnd_pix);
		expect_map(w, h, c);
		configure(w, h, c);
		reg_write(REG_CTRL, 32'h1);
		send_pixels(0, w * h * c);
		while (!itr)
			@(negedge clk);
		@(posedge clk);
		#1;
		check_word("beat count", 32'(2 * w * h * c), 32'(beats_seen));
		check_word("beats left", 32'd0, 32'(exp_q.size()));
		reg_read(REG_STATUS, status);
		check_word("status", 32'h2, status); // done, not busy
		reg_write(REG_STATUS, 32'h0);
	endtask

	task automatic test_reset_readback();
		logic[31:0] word;
		map_dims_t dims;
		test_name = "reset_readback";
		check_word("out_valid", 32'd0, 32'(out_valid));
		check_word("in_ready", 32'd0, 32'(in_ready));
		check_word("itr", 32'd0, 32'(itr));
		reg_read(REG_STATUS, word);
		check_word("status", 32'd0, word);
		dims.w_m1 = 16'd37;
		dims.h_m1 = 16'd21;
		reg_write(REG_DIMS, dims);
		reg_read(REG_DIMS, word);
		check_word("dims", dims, word);
		reg_write(REG_CHN, 32'd11);
		reg_read(REG_CHN, word);
		check_word("chn", 32'd11, word);
	endtask

	task automatic test_done_behaviour();
		logic[31:0] status;
		test_name = "done_behaviour";
		ready_random = 1'b0;
		beats_seen = 0;
		fill_pixels(4, 1'b0);
		expect_map(2, 2, 1);
		configure(2, 2, 1);
		reg_write(REG_CTRL, 32'h1);
		reg_read(REG_STATUS, status);
		check_word("busy after start", 32'h1, status);
		send_pixels(0, 2);
		reg_write(REG_CTRL, 32'h1); // second start mid run, should change nothing
		send_pixels(2, 2);
		@(negedge clk);
		while (!(out_valid && out_beat.last))
			@(negedge clk);
		@(negedge clk);
		check_word("itr after last", 32'h1, 32'(itr));
		@(posedge clk);
		#1;
		reg_read(REG_STATUS, status);
		check_word("status after last", 32'h2, status);
		repeat (5) @(posedge clk);
		#1;
		check_word("itr held", 32'h1, 32'(itr));
		reg_write(REG_STATUS, 32'h0);
		reg_read(REG_STATUS, status);
		check_word("status after clear", 32'h0, status);
		check_word("itr after clear", 32'h0, 32'(itr));
		check_word("beat count", 32'd8, 32'(beats_seen));
	endtask

	// beats are taken at the edge after a mid cycle sample shows valid and ready
	initial begin
		forever begin
			@(negedge clk);
			if (!reset && out_valid && out_ready) begin
				if (exp_q.size() == 0)
					stop_on_error($sformatf("%s: output beat when none was expected", test_name));
				else
					check_beat(exp_q.pop_front(), out_beat);
				beats_seen++;
			end
		end
	end

	initial begin
		forever begin
			@(posedge clk);
			#1;
			out_ready = ready_random ? ($urandom_range(3) != 0) : 1'b1;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired in %s, the DUT stopped making progress", test_name);
		$display("sim failed");
		$fatal(1, "timeout");
	end

	initial begin
		void'($urandom(32'h7009));
		reg_wr = 1'b0;
		reg_rd = 1'b0;
		reg_addr = REG_CTRL;
		reg_wdata = '0;
		in_valid = 1'b0;
		in_pixel = '0;
		out_ready = 1'b0;
		ready_random = 1'b0;
		test_name = "reset";
		@(negedge reset);
		@(posedge clk);
		#1;
		test_reset_readback();
		run_map("map_2x3", 2, 3, 1, 1'b0, 1'b0);
		run_map("map_4x2x3", 4, 2, 3, 1'b1, 1'b0);
		run_map("backpressure_5x4x2", 5, 4, 2, 1'b1, 1'b1);
		test_done_behaviour();
		run_map("max_width", `MAX_MAP_W, 1, 1, 1'b1, 1'b0);
		$display("sim passed");
		$finish;
	end

endmodule

// ==== dv/upsample_assert.sv ====
`timescale 1ns/10ps

module upsample_assert (
	input logic clk,
	input logic reset,
	input logic busy,
	input logic in_ready,
	input logic out_valid,
	input logic out_ready,
	input upsample_stream_pkg::out_beat_t out_beat,
	input logic frame_done
);

	// a stalled beat keeps its payload until taken
	property beat_held;
		@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_beat);
	endproperty

	// no input taken and no beat offered while idle
	property idle_quiet;
		@(posedge clk) disable iff (reset)
		!busy |-> !in_ready && !out_valid;
	endproperty

	// run ends with its last beat, so only one last per run
	property single_last;
		@(posedge clk) disable iff (reset)
		frame_done |=> !busy;
	endproperty

	assert property (beat_held) else $error("output beat changed while stalled");
	assert property (idle_quiet) else $error("stream active while idle");
	assert property (single_last) else $error("run continued after the last beat");

endmodule

// ==== dv/tb_clkgen.sv ====
`timescale 1ns/10ps

module tb_clkgen #(
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
	end

endmodule

// ==== hw/upsample_top.sv ====
`timescale 1ns/10ps
`include "upsample_macros.svh"

module upsample_top (
	input logic clk,
	input logic reset,

	// register port
	input logic reg_wr,
	input logic reg_rd,
	input upsample_cfg_pkg::reg_addr_e reg_addr,
	input logic[31:0] reg_wdata,
	output logic[31:0] reg_rdata,

	// feature input, one pixel per beat
	input logic in_valid,
	output logic in_ready,
	input upsample_stream_pkg::pixel_t in_pixel,

	// doubled output, two pixels per beat
	output logic out_valid,
	input logic out_ready,
	output upsample_stream_pkg::out_beat_t out_beat,

	output logic itr
);

	import upsample_cfg_pkg::*;
	import upsample_stream_pkg::*;

	map_cfg_t cfg;
	logic start;
	logic busy;
	logic frame_done;

	pos_info_t pos;
	logic advance;
	logic[`COORD_BITS-1:0] rd_x;
	pixel_t rd_pixel;

	logic wr_en;
	logic[`COORD_BITS-1:0] wr_x;
	pixel_t wr_pixel;

	upsample_regs upsample_regs_u(
		.clk(clk),
		.reset(reset),
		.reg_wr(reg_wr),
		.reg_rd(reg_rd),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_rdata(reg_rdata),
		.frame_done(frame_done),
		.cfg(cfg),
		.start(start),
		.busy(busy),
		.itr(itr)
	);

	// position and pass of the next beat
	map_tracker map_tracker_u(
		.clk(clk),
		.reset(reset),
		.start(start),
		.cfg(cfg),
		.advance(advance),
		.pos(pos),
		.rd_x(rd_x)
	);

	row_buffer row_buffer_u(
		.clk(clk),
		.wr_en(wr_en),
		.wr_x(wr_x),
		.wr_pixel(wr_pixel),
		.rd_x(rd_x),
		.rd_pixel(rd_pixel)
	);

	row_doubler row_doubler_u(
		.clk(clk),
		.reset(reset),
		.busy(busy),
		.pos(pos),
		.rd_pixel(rd_pixel),
		.in_valid(in_valid),
		.in_pixel(in_pixel),
		.in_ready(in_ready),
		.wr_en(wr_en),
		.wr_x(wr_x),
		.wr_pixel(wr_pixel),
		.advance(advance),
		.out_ready(out_ready),
		.out_valid(out_valid),
		.out_beat(out_beat),
		.frame_done(frame_done)
	);

endmodule

// ==== hw/row_doubler.sv ====
`timescale 1ns/10ps
`include "upsample_macros.svh"

module row_doubler (
	input logic clk,
	input logic reset,
	input logic busy,
	input upsample_stream_pkg::pos_info_t pos,
	input upsample_stream_pkg::pixel_t rd_pixel, // replayed pixel from the buffer

	// input stream
	input logic in_valid,
	input upsample_stream_pkg::pixel_t in_pixel,
	output logic in_ready,

	// buffer write
	output logic wr_en,
	output logic[`COORD_BITS-1:0] wr_x,
	output upsample_stream_pkg::pixel_t wr_pixel,

	output logic advance,

	// output stream
	input logic out_ready,
	output logic out_valid,
	output upsample_stream_pkg::out_beat_t out_beat,

	output logic frame_done
);

	import upsample_stream_pkg::*;

	logic live;
	logic can_load; // output register free this cycle
	logic load;
	pixel_t src_pixel;

	assign live = pos.pass == PASS_LIVE;

	// nothing new goes in behind the last beat of a map
	assign can_load = !out_valid || (out_ready && !out_beat.last);

	assign in_ready = busy && live && can_load;

	// the replay pass never waits on the input
	assign load = live ? (in_valid && in_ready) : (busy && can_load);
	assign advance = load;

	assign src_pixel = live ? in_pixel : rd_pixel;

	// every live pixel is kept for the second copy of its row
	assign wr_en = load && live;
	assign wr_x = pos.x;
	assign wr_pixel = in_pixel;

	always_ff @(posedge clk) begin
		if (reset)
			out_valid <= 1'b0;
		else if (load)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	// held while the sink stalls
	always_ff @(posedge clk) begin
		if (load) begin
			out_beat.data <= {src_pixel, src_pixel};
			out_beat.last <= pos.map_end;
		end
	end

	assign frame_done = out_valid && out_ready && out_beat.last;

endmodule

// ==== hw/map_tracker.sv ====
`timescale 1ns/10ps
`include "upsample_macros.svh"

module map_tracker (
	input logic clk,
	input logic reset,
	input logic start,
	input upsample_cfg_pkg::map_cfg_t cfg,
	input logic advance, // one per output beat loaded

	output upsample_stream_pkg::pos_info_t pos,
	output logic[`COORD_BITS-1:0] rd_x // buffer address for the next cycle
);

	import upsample_stream_pkg::*;

	logic[`COORD_BITS-1:0] x;
	logic[`COORD_BITS-1:0] y;
	logic[`CHN_BITS-1:0] chn;
	pass_e pass;

	logic row_end;
	logic y_last;
	logic chn_last;
	logic[`COORD_BITS-1:0] x_next;

	assign row_end = x == cfg.dims.w_m1[`COORD_BITS-1:0];
	assign y_last = y == cfg.dims.h_m1[`COORD_BITS-1:0];
	assign chn_last = chn == cfg.chn_m1[`CHN_BITS-1:0];

	assign pos.pass = pass;
	assign pos.x = x;
	assign pos.row_end = row_end;
	assign pos.map_end = row_end && (pass == PASS_REPLAY) && y_last && chn_last;

	// look ahead so the sync memory has the pixel ready when pos moves
	assign x_next = row_end ? '0 : x + 1'b1;
	assign rd_x = advance ? x_next : x;

	// x inside pass inside row inside channel
	always_ff @(posedge clk) begin
		if (reset || start) begin
			x <= '0;
			y <= '0;
			chn <= '0;
			pass <= PASS_LIVE;
		end else if (advance) begin
			x <= x_next;
			if (row_end) begin
				if (pass == PASS_LIVE) begin
					pass <= PASS_REPLAY;
				end else begin
					pass <= PASS_LIVE;
					y <= y_last ? '0 : y + 1'b1;
					if (y_last)
						chn <= chn_last ? '0 : chn + 1'b1; // wraps after the map
				end
			end
		end
	end

endmodule

// ==== hw/row_buffer.sv ====
`timescale 1ns/10ps
`include "upsample_macros.svh"

module row_buffer (
	input logic clk,

	// write side, live pass
	input logic wr_en,
	input logic[`COORD_BITS-1:0] wr_x,
	input upsample_stream_pkg::pixel_t wr_pixel,

	// read side, one cycle latency
	input logic[`COORD_BITS-1:0] rd_x,
	output upsample_stream_pkg::pixel_t rd_pixel
);

	import upsample_stream_pkg::*;

	// holds one input row of the current channel
	pixel_t mem[`MAX_MAP_W];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_x] <= wr_pixel;
	end

	// new data is passed straight through when both ports hit the same column,
	// which only happens on a one pixel wide map
	always_ff @(posedge clk) begin
		if (wr_en && (wr_x == rd_x))
			rd_pixel <= wr_pixel;
		else
			rd_pixel <= mem[rd_x];
	end

endmodule

// ==== hw/upsample_regs.sv ====
`timescale 1ns/10ps

module upsample_regs (
	input logic clk,
	input logic reset,

	// strobe register port
	input logic reg_wr,
	input logic reg_rd,
	input upsample_cfg_pkg::reg_addr_e reg_addr,
	input logic[31:0] reg_wdata,
	output logic[31:0] reg_rdata,

	input logic frame_done, // last beat accepted

	output upsample_cfg_pkg::map_cfg_t cfg,
	output logic start,
	output logic busy,
	output logic itr
);

	import upsample_cfg_pkg::*;

	cfg_word_u wr_word;
	cfg_word_u rd_word;
	logic done; // sticky until a status write

	assign wr_word.raw = reg_wdata;

	// one cycle pulse, dropped while a map is running
	assign start = reg_wr && (reg_addr == REG_CTRL) && reg_wdata[0] && !busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			cfg <= '0;
		end else if (reg_wr) begin
			if (reg_addr == REG_DIMS)
				cfg.dims <= wr_word.dims;
			if (reg_addr == REG_CHN)
				cfg.chn_m1 <= wr_word.raw[15:0];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			if (start)
				busy <= 1'b1;
			else if (frame_done)
				busy <= 1'b0;

			// a finishing frame wins over a clear in the same cycle
			if (frame_done)
				done <= 1'b1;
			else if (reg_wr && (reg_addr == REG_STATUS))
				done <= 1'b0;
		end
	end

	always_comb begin
		rd_word.raw = '0; // ctrl reads as zero
		case (reg_addr)
			REG_DIMS: rd_word.dims = cfg.dims;
			REG_CHN: rd_word.raw = {16'd0, cfg.chn_m1};
			REG_STATUS: rd_word.raw = {30'd0, done, busy};
			default: rd_word.raw = '0;
		endcase
	end

	// read data lands one cycle after the strobe
	always_ff @(posedge clk) begin
		if (reg_rd)
			reg_rdata <= rd_word.raw;
	end

	assign itr = done;

endmodule

// ==== hw/upsample_stream_pkg.sv ====
`include "upsample_macros.svh"

package upsample_stream_pkg;

	typedef logic[`FEATURE_W_BITS-1:0] pixel_t;

	// first pass takes the stream, second replays the stored row
	typedef enum logic {
		PASS_LIVE = 1'b0,
		PASS_REPLAY = 1'b1
	} pass_e;

	// where the next output beat sits in the map
	typedef struct packed {
		pass_e pass;
		logic[`COORD_BITS-1:0] x;
		logic row_end; // last column of this pass
		logic map_end; // last beat of the whole map
	} pos_info_t;

	// output payload, the pixel twice side by side
	typedef struct packed {
		pixel_t[1:0] data;
		logic last;
	} out_beat_t;

endpackage

// ==== hw/upsample_cfg_pkg.sv ====
package upsample_cfg_pkg;

	// strobe bus register map
	typedef enum logic[1:0] {
		REG_CTRL = 2'd0, // bit 0 starts a map
		REG_DIMS = 2'd1, // width-1 and height-1
		REG_CHN = 2'd2, // channels-1
		REG_STATUS = 2'd3 // bit 0 busy, bit 1 done, write clears done
	} reg_addr_e;

	// one register word, width in the upper half
	typedef struct packed {
		logic[15:0] w_m1;
		logic[15:0] h_m1;
	} map_dims_t;

	// a register word seen as plain bits or as the dims layout
	typedef union packed {
		logic[31:0] raw;
		map_dims_t dims;
	} cfg_word_u;

	// full map configuration handed to the tracker
	typedef struct packed {
		map_dims_t dims;
		logic[15:0] chn_m1;
	} map_cfg_t;

endpackage

// ==== hw/upsample_macros.svh ====
`ifndef UPSAMPLE_MACROS_SVH
`define UPSAMPLE_MACROS_SVH

// feature data width, one feature per beat
`define FEATURE_W_BITS 16

// map size limits
`define MAX_MAP_W 64
`define MAX_MAP_H 64
`define MAX_MAP_CHN 16

// counter widths, sized for the limits above
`define COORD_BITS 6 // x and y
`define CHN_BITS 4

`endif
